// ==== memSystem_consts.svh ====
//####################################################################
// memory system constants
// address split, line size, bank count and memory timing
//####################################################################
`ifndef MEMSYSTEM_CONSTS_SVH
`define MEMSYSTEM_CONSTS_SVH

// byte address split for the direct-mapped cache
`define TAG_W 5
`define INDEX_W 8
`define OFFSET_W 3

// 16-bit words per cache line
`define LINE_WORDS 4

// backing memory banks, picked by address bits 2 to 1
`define NUM_BANKS 4

// cycles a bank stays occupied after an accepted access
`define BANK_BUSY 4
// accepted read to data out
`define RD_LAT 2

`endif

// ==== memSysPkg.sv ====
//####################################################################
// memory system types
// data word, two-view address word and controller states
//####################################################################
`include "memSystem_consts.svh"

package memSysPkg;

   typedef logic [15:0] word_t;

   // row within a bank holds the tag and index bits
   typedef logic [`TAG_W+`INDEX_W-1:0] row_t;

   // cache view of an address
   typedef struct packed {
      logic [`TAG_W-1:0]    tag;
      logic [`INDEX_W-1:0]  index;
      logic [`OFFSET_W-1:0] offset;
   } cacheView_t;

   // memory view of the same address
   typedef struct packed {
      row_t                          row;
      logic [$clog2(`NUM_BANKS)-1:0] bank;
      logic                          byteSel;
   } bankView_t;

   typedef union packed {
      cacheView_t cache;
      bankView_t  bank;
   } addr_u;

   // miss handling FSM states with code 14 left unused
   typedef enum logic [4:0] {
      IDLE          = 5'd0,
      COMP_RD       = 5'd1,
      COMP_WR       = 5'd2,
      RD_B0         = 5'd3,
      RD_B1         = 5'd4,
      RDB2_WRB0     = 5'd5,
      RDB3_WRB1     = 5'd6,
      WR_B2         = 5'd7,
      WR_B3         = 5'd8,
      EVICT_B0      = 5'd9,
      EVICT_B1      = 5'd10,
      EVICT_B2      = 5'd11,
      EVICT_B3      = 5'd12,
      FINALLY_WRITE = 5'd13,
      DONE          = 5'd15,
      WRITE_DONE    = 5'd16
   } ctrlState_e;

endpackage

// ==== cacheArray.sv ====
//####################################################################
// direct-mapped cache store
// tag, valid, dirty and data per line, combinational compare and read
//####################################################################
`timescale 1ns/1ps
`include "memSystem_consts.svh"

module cacheArray (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 comp,
   input  logic                 write,
   input  memSysPkg::addr_u     addr,
   input  memSysPkg::word_t     dataIn,
   output memSysPkg::word_t     dataOut,
   output logic                 hit,
   output logic                 dirty,
   output logic                 valid,
   output logic [`TAG_W-1:0]    tagOut,
   output logic                 err
);

   localparam int LINES  = 2 ** `INDEX_W;
   localparam int WORD_W = $clog2(`LINE_WORDS);

   // line storage
   logic [`TAG_W-1:0] tagMem [LINES];
   logic [LINES-1:0]  validMem;
   logic [LINES-1:0]  dirtyMem;
   memSysPkg::word_t  dataMem [LINES][`LINE_WORDS];

   logic [`INDEX_W-1:0] index;
   logic [WORD_W-1:0]   word;
   logic                tagMatch;
   logic                doWrite;

   //####################################################################
   // lookup
   //####################################################################

   assign index = addr.cache.index;
   // word within the line, offset without its byte bit
   assign word  = addr.cache.offset[`OFFSET_W-1:1];

   assign tagOut   = tagMem[index];
   assign dataOut  = dataMem[index][word];
   assign valid    = validMem[index];
   // a stale dirty bit on an invalid line never asks for eviction
   assign dirty    = validMem[index] & dirtyMem[index];
   assign tagMatch = (tagMem[index] == addr.cache.tag);
   assign hit      = enable & comp & validMem[index] & tagMatch;

   // unaligned word access
   assign err = enable & addr.cache.offset[0];

   assign doWrite = enable & write;

   //####################################################################
   // update
   //####################################################################

   // valid bits are the only state cleared by reset
   always_ff @(posedge clk) begin
      if (reset) begin
         validMem <= '0;
      end else if (doWrite && !comp) begin
         validMem[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (doWrite && !comp) begin
         // line fill word, takes over the line for the new tag
         tagMem[index]        <= addr.cache.tag;
         dirtyMem[index]      <= 1'b0;
         dataMem[index][word] <= dataIn;
      end else if (doWrite && hit) begin
         // store hit
         dirtyMem[index]      <= 1'b1;
         dataMem[index][word] <= dataIn;
      end
      // compare write on a miss leaves the line alone
   end

   // the controller never strobes write on an idle cache
   assert property (@(posedge clk) disable iff (reset) write |-> enable);

endmodule

// ==== fourBankMem.sv ====
//####################################################################
// four-bank backing memory
// per-bank busy timers and stall, reads returned after a fixed delay
//####################################################################
`timescale 1ns/1ps
`include "memSystem_consts.svh"

module fourBankMem (
   input  logic             clk,
   input  logic             reset,
   input  memSysPkg::addr_u addr,
   input  memSysPkg::word_t dataIn,
   input  logic             rd,
   input  logic             wr,
   output memSysPkg::word_t dataOut,
   output logic             stall,
   output logic             err
);

   localparam int ROWS   = 2 ** $bits(memSysPkg::row_t);
   localparam int BANK_W = $clog2(`NUM_BANKS);
   localparam int CNT_W  = $clog2(`BANK_BUSY);
   // delay stages ahead of the output register
   localparam int PIPE   = `RD_LAT - 1;

   memSysPkg::word_t bankMem [`NUM_BANKS][ROWS];
   logic [CNT_W-1:0] busyCnt [`NUM_BANKS];

   logic [BANK_W-1:0] bankSel;
   memSysPkg::row_t   rowSel;
   logic              accept;
   logic [PIPE-1:0]   rdValid;
   memSysPkg::word_t  rdData [PIPE];

   assign bankSel = addr.bank.bank;
   assign rowSel  = addr.bank.row;

   // addressed bank still counting down, nothing accepted this cycle
   assign stall  = (rd | wr) & (busyCnt[bankSel] != '0);
   assign accept = (rd ^ wr) & ~stall;
   assign err    = (rd & wr) | ((rd | wr) & addr.bank.byteSel);

   //####################################################################
   // bank timers
   //####################################################################

   always_ff @(posedge clk) begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
         if (reset) begin
            busyCnt[b] <= '0;
         end else if (accept && bankSel == BANK_W'(b)) begin
            // acceptance cycle counts as the first busy cycle
            busyCnt[b] <= CNT_W'(`BANK_BUSY - 1);
         end else if (busyCnt[b] != '0) begin
            busyCnt[b] <= busyCnt[b] - 1'b1;
         end
      end
   end

   //####################################################################
   // storage and read delay line
   //####################################################################

   // memory starts out all zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            for (int r = 0; r < ROWS; r++) begin
               bankMem[b][r] <= '0;
            end
         end
      end else if (accept && wr) begin
         bankMem[bankSel][rowSel] <= dataIn;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rdValid <= '0;
      end else begin
         rdValid <= (rdValid << 1) | PIPE'(accept & rd);
      end
   end

   always_ff @(posedge clk) begin
      rdData[0] <= bankMem[bankSel][rowSel];
      for (int i = 1; i < PIPE; i++) begin
         rdData[i] <= rdData[i-1];
      end
      // output holds until the next read lands
      if (rdValid[PIPE-1]) begin
         dataOut <= rdData[PIPE-1];
      end
   end

   // no bank accepts two accesses inside its busy window
   for (genvar k = 1; k < `BANK_BUSY; k++) begin : gBusyWindow
      assert property (@(posedge clk) disable iff (reset)
         (accept && wr) |-> !($past(accept, k) && $past(bankSel, k) == bankSel));
   end

endmodule

// ==== cacheController.sv ====
//####################################################################
// cache miss controller
// compare, dirty line eviction, line fill and the pending store
//####################################################################
`timescale 1ns/1ps
`include "memSystem_consts.svh"

module cacheController (
   input  logic                 clk,
   input  logic                 reset,
   input  memSysPkg::addr_u     Addr,
   input  memSysPkg::word_t     DataIn,
   input  logic                 Rd,
   input  logic                 Wr,
   input  logic                 cacheHit,
   input  logic                 cacheDirty,
   input  logic                 cacheValid,
   input  logic [`TAG_W-1:0]    cacheTag,
   input  logic                 cacheErr,
   input  memSysPkg::word_t     cacheData,
   input  memSysPkg::word_t     memData,
   input  logic                 memStall,
   output logic                 cacheEnable,
   output logic                 cacheComp,
   output logic                 cacheWrite,
   output memSysPkg::addr_u     cacheAddr,
   output memSysPkg::word_t     cacheDataIn,
   output memSysPkg::addr_u     memAddr,
   output logic                 memRd,
   output logic                 memWr,
   output logic                 Done,
   output logic                 Stall,
   output logic                 CacheHit
);

   localparam int BANK_W = $clog2(`NUM_BANKS);

   memSysPkg::ctrlState_e state;
   memSysPkg::ctrlState_e nextState;
   memSysPkg::ctrlState_e reqState;
   memSysPkg::ctrlState_e compState;
   logic [BANK_W-1:0]     evictWord;

   // address of one word of the requested line under a given tag
   function automatic memSysPkg::addr_u wordAddr(
      input memSysPkg::addr_u  base,
      input logic [`TAG_W-1:0] tag,
      input logic [BANK_W-1:0] word
   );
      memSysPkg::addr_u a;
      a = base;
      a.cache.tag    = tag;
      a.cache.offset = {word, 1'b0};
      return a;
   endfunction

   //####################################################################
   // request decode and compare outcome
   //####################################################################

   // both or neither strobe means no request
   always_comb begin
      if (Rd && !Wr) begin
         reqState = memSysPkg::COMP_RD;
      end else if (Wr && !Rd) begin
         reqState = memSysPkg::COMP_WR;
      end else begin
         reqState = memSysPkg::IDLE;
      end
   end

   // a bad address ends the request without touching memory
   always_comb begin
      if (cacheErr || (cacheHit && cacheValid)) begin
         compState = memSysPkg::DONE;
      end else if (cacheDirty) begin
         compState = memSysPkg::EVICT_B0;
      end else begin
         compState = memSysPkg::RD_B0;
      end
   end

   // eviction states are consecutive, one per line word
   assign evictWord = BANK_W'(state - memSysPkg::EVICT_B0);

   assign Stall = !(state inside {memSysPkg::IDLE, memSysPkg::DONE, memSysPkg::WRITE_DONE});

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= memSysPkg::IDLE;
      end else begin
         state <= nextState;
      end
   end

   //####################################################################
   // state outputs and transitions
   //####################################################################

   always_comb begin
      cacheEnable = 1'b0;
      cacheComp   = 1'b0;
      cacheWrite  = 1'b0;
      cacheAddr   = Addr;
      cacheDataIn = DataIn;
      memAddr     = wordAddr(Addr, Addr.cache.tag, '0);
      memRd       = 1'b0;
      memWr       = 1'b0;
      Done        = 1'b0;
      CacheHit    = 1'b0;
      nextState   = state;
      unique case (state)
         memSysPkg::IDLE: begin
            cacheEnable = Rd ^ Wr;
            nextState   = reqState;
         end
         memSysPkg::COMP_RD: begin
            cacheEnable = 1'b1;
            cacheComp   = 1'b1;
            nextState   = compState;
         end
         memSysPkg::COMP_WR: begin
            cacheEnable = 1'b1;
            cacheComp   = 1'b1;
            // store lands only on a hit
            cacheWrite  = ~cacheErr;
            nextState   = compState;
         end
         memSysPkg::EVICT_B0, memSysPkg::EVICT_B1,
         memSysPkg::EVICT_B2, memSysPkg::EVICT_B3: begin
            // old line goes back to memory under its own tag
            cacheEnable = 1'b1;
            cacheAddr   = wordAddr(Addr, Addr.cache.tag, evictWord);
            memAddr     = wordAddr(Addr, cacheTag, evictWord);
            memWr       = 1'b1;
            if (!memStall) begin
               nextState = (state == memSysPkg::EVICT_B3) ? memSysPkg::RD_B0
                         : memSysPkg::ctrlState_e'(state + 5'd1);
            end
         end
         memSysPkg::RD_B0: begin
            memRd = 1'b1;
            if (!memStall) nextState = memSysPkg::RD_B1;
         end
         memSysPkg::RD_B1: begin
            memRd   = 1'b1;
            memAddr = wordAddr(Addr, Addr.cache.tag, BANK_W'(1));
            if (!memStall) nextState = memSysPkg::RDB2_WRB0;
         end
         memSysPkg::RDB2_WRB0: begin
            // word 0 has arrived while word 2 is requested
            memRd       = 1'b1;
            memAddr     = wordAddr(Addr, Addr.cache.tag, BANK_W'(2));
            cacheEnable = 1'b1;
            cacheWrite  = 1'b1;
            cacheAddr   = wordAddr(Addr, Addr.cache.tag, BANK_W'(0));
            cacheDataIn = memData;
            if (!memStall) nextState = memSysPkg::RDB3_WRB1;
         end
         memSysPkg::RDB3_WRB1: begin
            memRd       = 1'b1;
            memAddr     = wordAddr(Addr, Addr.cache.tag, BANK_W'(3));
            cacheEnable = 1'b1;
            cacheWrite  = 1'b1;
            cacheAddr   = wordAddr(Addr, Addr.cache.tag, BANK_W'(1));
            cacheDataIn = memData;
            if (!memStall) nextState = memSysPkg::WR_B2;
         end
         memSysPkg::WR_B2: begin
            cacheEnable = 1'b1;
            cacheWrite  = 1'b1;
            cacheAddr   = wordAddr(Addr, Addr.cache.tag, BANK_W'(2));
            cacheDataIn = memData;
            nextState   = memSysPkg::WR_B3;
         end
         memSysPkg::WR_B3: begin
            cacheEnable = 1'b1;
            cacheWrite  = 1'b1;
            cacheAddr   = wordAddr(Addr, Addr.cache.tag, BANK_W'(3));
            cacheDataIn = memData;
            // a store still has to merge into the fresh line
            nextState   = (Wr && !Rd) ? memSysPkg::FINALLY_WRITE : memSysPkg::WRITE_DONE;
         end
         memSysPkg::FINALLY_WRITE: begin
            cacheEnable = 1'b1;
            cacheComp   = 1'b1;
            cacheWrite  = 1'b1;
            nextState   = memSysPkg::WRITE_DONE;
         end
         memSysPkg::WRITE_DONE: begin
            cacheEnable = 1'b1;
            Done        = 1'b1;
            nextState   = reqState;
         end
         memSysPkg::DONE: begin
            cacheEnable = 1'b1;
            Done        = 1'b1;
            // aborted requests end here too, but never as a hit
            CacheHit    = ~cacheErr;
            nextState   = reqState;
         end
         default: begin
            nextState = memSysPkg::IDLE;
         end
      endcase
   end

   // requester drops its strobe on Done, so no back-to-back Done
   assert property (@(posedge clk) disable iff (reset) Done |=> !Done);
   assert property (@(posedge clk) disable iff (reset) !(memRd && memWr));

endmodule

// ==== memSystem.sv ====
//####################################################################
// memory system top
// miss controller, cache store and four-bank memory
//####################################################################
`timescale 1ns/1ps
`include "memSystem_consts.svh"

module memSystem (
   input  logic             clk,
   input  logic             reset,
   input  memSysPkg::addr_u Addr,
   input  memSysPkg::word_t DataIn,
   input  logic             Rd,
   input  logic             Wr,
   output memSysPkg::word_t DataOut,
   output logic             Done,
   output logic             Stall,
   output logic             CacheHit,
   output logic             err
);

   // cache side
   logic                 cacheEnable;
   logic                 cacheComp;
   logic                 cacheWrite;
   memSysPkg::addr_u     cacheAddr;
   memSysPkg::word_t     cacheDataIn;
   memSysPkg::word_t     cacheData;
   logic                 cacheHit;
   logic                 cacheDirty;
   logic                 cacheValid;
   logic [`TAG_W-1:0]    cacheTag;
   logic                 cacheErr;

   // memory side
   memSysPkg::addr_u     memAddr;
   memSysPkg::word_t     memData;
   logic                 memRd;
   logic                 memWr;
   logic                 memStall;
   logic                 memErr;

   // cache word goes out and doubles as eviction write data
   assign DataOut = cacheData;
   assign err     = cacheErr | memErr;

   cacheController i_ctrl (
      .clk(clk), .reset(reset),
      .Addr(Addr), .DataIn(DataIn), .Rd(Rd), .Wr(Wr),
      .cacheHit(cacheHit), .cacheDirty(cacheDirty), .cacheValid(cacheValid),
      .cacheTag(cacheTag), .cacheErr(cacheErr), .cacheData(cacheData),
      .memData(memData), .memStall(memStall),
      .cacheEnable(cacheEnable), .cacheComp(cacheComp), .cacheWrite(cacheWrite),
      .cacheAddr(cacheAddr), .cacheDataIn(cacheDataIn),
      .memAddr(memAddr), .memRd(memRd), .memWr(memWr),
      .Done(Done), .Stall(Stall), .CacheHit(CacheHit)
   );

   cacheArray i_cache (
      .clk(clk), .reset(reset),
      .enable(cacheEnable), .comp(cacheComp), .write(cacheWrite),
      .addr(cacheAddr), .dataIn(cacheDataIn), .dataOut(cacheData),
      .hit(cacheHit), .dirty(cacheDirty), .valid(cacheValid),
      .tagOut(cacheTag), .err(cacheErr)
   );

   fourBankMem i_mem (
      .clk(clk), .reset(reset),
      .addr(memAddr), .dataIn(cacheData), .rd(memRd), .wr(memWr),
      .dataOut(memData), .stall(memStall), .err(memErr)
   );

endmodule

// ==== tbMemSystem.sv ====
//####################################################################
// memory system testbench
// directed and random cache traffic checked against a reference model
//####################################################################
`timescale 1ns/1ps
`include "memSystem_consts.svh"

module tbMemSystem;

   localparam int TIMEOUT = 2000;
   localparam int LINES   = 2 ** `INDEX_W;

   // one finished request with expected and observed values side by side
   typedef struct packed {
      logic [15:0]      addr;
      logic             cmpData;
      memSysPkg::word_t expData;
      memSysPkg::word_t gotData;
      logic             expHit;
      logic             gotHit;
      logic             expErr;
      logic             gotErr;
   } resp_t;

   logic             clk;
   logic             reset;
   memSysPkg::addr_u addr;
   memSysPkg::word_t dataIn;
   logic             rd;
   logic             wr;
   memSysPkg::word_t dataOut;
   logic             done;
   logic             stall;
   logic             cacheHit;
   logic             err;

   // reference state is a word memory plus a tag shadow per index
   memSysPkg::word_t  refMem [logic [15:0]];
   logic [`TAG_W-1:0] shadowTag [LINES];
   logic [LINES-1:0]  shadowValid;
   resp_t             respQ [$];
   int unsigned       rndSeed;

   memSystem i_dut (
      .clk(clk), .reset(reset),
      .Addr(addr), .DataIn(dataIn), .Rd(rd), .Wr(wr),
      .DataOut(dataOut), .Done(done), .Stall(stall), .CacheHit(cacheHit), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //####################################################################
   // failure reporting and compare tasks
   //####################################################################

   task automatic failRun(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic checkData(input string name, input memSysPkg::word_t got,
                            input memSysPkg::word_t exp, input logic [15:0] a);
      if (got !== exp) begin
         failRun($sformatf("ERROR %s got %h expected %h at address %h", name, got, exp, a));
      end
   endtask

   task automatic checkHit(input string name, input logic got, input logic exp,
                           input logic [15:0] a);
      if (got !== exp) begin
         failRun($sformatf("ERROR %s got %h expected %h at address %h", name, got, exp, a));
      end
   endtask

   // status bits other than the hit flag
   task automatic checkFlag(input string name, input logic got, input logic exp,
                            input logic [15:0] a);
      if (got !== exp) begin
         failRun($sformatf("ERROR %s got %h expected %h at address %h", name, got, exp, a));
      end
   endtask

   //####################################################################
   // reference model
   //####################################################################

   // last word stored at an address or zero if never written
   function automatic memSysPkg::word_t refRead(input logic [15:0] a);
      if (refMem.exists(a)) begin
         return refMem[a];
      end
      return '0;
   endfunction

   // direct mapped with every access allocating its line
   function automatic logic refHit(input memSysPkg::addr_u a);
      logic h;
      h = shadowValid[a.cache.index] && (shadowTag[a.cache.index] == a.cache.tag);
      shadowValid[a.cache.index] = 1'b1;
      shadowTag[a.cache.index]   = a.cache.tag;
      return h;
   endfunction

   function automatic memSysPkg::addr_u makeAddr(input logic [`TAG_W-1:0] tag,
                                                 input logic [`INDEX_W-1:0] index,
                                                 input logic [1:0] word);
      memSysPkg::addr_u a;
      a.cache.tag    = tag;
      a.cache.index  = index;
      a.cache.offset = {word, 1'b0};
      return a;
   endfunction

   //####################################################################
   // request driving
   //####################################################################

   // hold the strobe until Done and note any err seen on the way
   task automatic runRequest(input logic isWrite, input memSysPkg::addr_u a,
                             input memSysPkg::word_t d, output memSysPkg::word_t gotData,
                             output logic gotHit, output logic gotErr);
      int cycles;
      logic finished;
      memSysPkg::ctrlState_e st;
      @(negedge clk);
      addr     = a;
      dataIn   = d;
      rd       = !isWrite;
      wr       = isWrite;
      cycles   = 0;
      finished = 1'b0;
      gotErr   = 1'b0;
      while (!finished) begin
         @(negedge clk);
         gotErr = gotErr | err;
         // busy while the request is in flight and free once it finishes
         checkFlag("Stall", stall, !done, a);
         if (done) begin
            finished = 1'b1;
            gotData  = dataOut;
            gotHit   = cacheHit;
            rd       = 1'b0;
            wr       = 1'b0;
         end else begin
            cycles++;
            if (cycles >= TIMEOUT) begin
               st = i_dut.i_ctrl.state;
               failRun($sformatf("Done never came for the request at address %h, FSM in %s",
                                 a, st.name()));
            end
         end
      end
   endtask

   task automatic access(input logic isWrite, input memSysPkg::addr_u a,
                         input memSysPkg::word_t d);
      resp_t r;
      memSysPkg::word_t gd;
      logic gh;
      logic ge;
      r.addr    = a;
      r.cmpData = !isWrite;
      r.expData = refRead(a);
      r.expHit  = refHit(a);
      r.expErr  = 1'b0;
      runRequest(isWrite, a, d, gd, gh, ge);
      if (isWrite) begin
         refMem[a] = d;
      end
      r.gotData = gd;
      r.gotHit  = gh;
      r.gotErr  = ge;
      respQ.push_back(r);
   endtask

   // unaligned read is aborted without a hit and leaves the line alone
   task automatic oddRead(input memSysPkg::addr_u a);
      resp_t r;
      memSysPkg::word_t gd;
      logic gh;
      logic ge;
      r.addr    = a;
      r.cmpData = 1'b0;
      r.expData = '0;
      r.expHit  = 1'b0;
      r.expErr  = 1'b1;
      runRequest(1'b0, a, '0, gd, gh, ge);
      r.gotData = gd;
      r.gotHit  = gh;
      r.gotErr  = ge;
      respQ.push_back(r);
   endtask

   // compare side picks up finished requests on the rising edge
   always @(posedge clk) begin
      resp_t r;
      if (respQ.size() > 0) begin
         r = respQ.pop_front();
         if (r.cmpData) begin
            checkData("DataOut", r.gotData, r.expData, r.addr);
         end
         checkHit("CacheHit", r.gotHit, r.expHit, r.addr);
         checkFlag("err", r.gotErr, r.expErr, r.addr);
      end
   end

   //####################################################################
   // test sequence
   //####################################################################

   initial begin
      memSysPkg::addr_u a;
      memSysPkg::addr_u b;
      int unsigned t;
      int unsigned ix;
      int unsigned w;
      int waitCycles;
      rndSeed     = $urandom(32'he8b1c727);
      reset       = 1'b1;
      rd          = 1'b0;
      wr          = 1'b0;
      addr        = '0;
      dataIn      = '0;
      shadowValid = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      checkFlag("Done", done, 1'b0, 16'h0);
      checkFlag("Stall", stall, 1'b0, 16'h0);
      checkFlag("CacheHit", cacheHit, 1'b0, 16'h0);
      checkFlag("err", err, 1'b0, 16'h0);

      // untouched lines read back as zero misses
      access(1'b0, makeAddr(5'd0, 8'd10, 2'd0), '0);
      access(1'b0, makeAddr(5'd7, 8'd200, 2'd3), '0);
      // store then load of the same word
      access(1'b1, makeAddr(5'd1, 8'd20, 2'd1), 16'h1234);
      access(1'b0, makeAddr(5'd1, 8'd20, 2'd1), '0);
      // same index with another tag sends the dirty line back to memory
      a = makeAddr(5'd2, 8'd30, 2'd2);
      b = makeAddr(5'd9, 8'd30, 2'd2);
      access(1'b1, a, 16'hbeef);
      access(1'b1, b, 16'hcafe);
      access(1'b0, a, '0);
      access(1'b0, b, '0);
      // other words of the line just filled
      access(1'b0, makeAddr(5'd9, 8'd30, 2'd0), '0);
      access(1'b1, makeAddr(5'd9, 8'd30, 2'd3), 16'h0f0f);
      access(1'b0, makeAddr(5'd9, 8'd30, 2'd3), '0);

      // random traffic over three indices and four tags
      for (int n = 0; n < 500; n++) begin
         t  = $urandom % 4;
         ix = $urandom % 3;
         w  = $urandom % 4;
         a  = makeAddr(5'(t), 8'(ix * 64 + 5), 2'(w));
         access(1'($urandom % 2), a, 16'($urandom));
      end

      // byte bit set and then normal traffic again
      a = makeAddr(5'd2, 8'd30, 2'd1);
      a.cache.offset[0] = 1'b1;
      oddRead(a);
      access(1'b0, makeAddr(5'd2, 8'd30, 2'd1), '0);
      access(1'b1, makeAddr(5'd3, 8'd31, 2'd0), 16'h5a5a);
      access(1'b0, makeAddr(5'd3, 8'd31, 2'd0), '0);

      waitCycles = 0;
      while (respQ.size() > 0) begin
         @(negedge clk);
         waitCycles++;
         if (waitCycles > TIMEOUT) begin
            failRun("the compare process never caught up with the finished requests");
         end
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+.
memSysPkg.sv
cacheArray.sv
fourBankMem.sv
cacheController.sv
memSystem.sv
tbMemSystem.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the memory system testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tbMemSystem \
   -f list.f \
   -o simMemSystem

./obj_dir/simMemSystem | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi

echo "simulation passed"
exit 0
